// File: turf_bridge_top.f
+incdir+design
+incdir+tb
design/turf_pkg.sv
design/turf_req_dispatch.sv
design/turfio_lane_bridge.sv
design/turf_id_regs.sv
design/turf_resp_merge.sv
design/turf_bridge_top.sv
tb/tb_turf_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the turf_bridge_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_turf_bridge -f turf_bridge_top.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_turf_bridge > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "tests failed" "$SIM_LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// File: tb/tb_turf_model.svh
`ifndef TB_TURF_MODEL_SVH
`define TB_TURF_MODEL_SVH

////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////

logic [31:0] rng_state;

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Crate address on a given lane, random lane offset
function automatic reg_addr_t crate_addr(input int lane);
    logic [31:0] r;
    r = next_random();
    return {1'b1, 2'(lane), r[24:0]};
endfunction

// Mostly the four ID words, sometimes anywhere in local space
function automatic reg_addr_t local_addr();
    logic [31:0] r;
    r = next_random();
    if (r[31:30] == 2'b00) begin
        return {1'b0, r[26:0]};
    end
    return {24'b0, r[3:0]};
endfunction

////////////////////////////////////////////////////////////
// Register and lane model
////////////////////////////////////////////////////////////

localparam logic [15:0] FW_DATE = `TURF_FW_DATE;

bridge_type_t model_btype = '0;
lane_flags_t  model_tmo   = '0;
lane_flags_t  model_inv   = '0;
lane_flags_t  model_up    = '0;
// Lanes whose far end never answers
lane_flags_t  silent      = '0;

task automatic predict_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata, output logic err, output logic cmd);
    int           lane;
    bridge_kind_t kind;
    rdata = '0;
    err   = 1'b0;
    cmd   = 1'b0;
    lane  = int'(addr[26:25]);
    kind  = bridge_kind_t'(model_btype[2*lane +: 2]);
    if (addr[27]) begin
        if (kind == BRIDGE_AURORA && model_up[lane]) begin
            cmd = 1'b1;
            if (silent[lane]) begin
                err             = 1'b1;
                model_tmo[lane] = 1'b1;
            end else begin
                rdata = {7'b0, addr[24:0]} ^ 32'h5A5A5A5A;
            end
        end else if (kind != BRIDGE_NONE) begin
            err             = 1'b1;
            model_inv[lane] = 1'b1;
        end
    end else if (addr[26:4] == '0) begin
        if (!wr) begin
            case (addr[3:2])
                2'd0:    rdata = `TURF_IDENT;
                2'd1:    rdata = {`TURF_REV_B, FW_DATE[14:0], `TURF_VER_MAJOR,
                                  `TURF_VER_MINOR, `TURF_VER_REV};
                2'd2:    rdata = {24'b0, model_btype};
                default: rdata = {24'b0, model_inv, model_tmo};
            endcase
        end else if (addr[3:2] == 2'd2) begin
            model_btype = wdata[7:0];
        end else if (addr[3:2] == 2'd3) begin
            // Write one to clear
            model_tmo = model_tmo & ~wdata[3:0];
            model_inv = model_inv & ~wdata[7:4];
        end
    end
endtask

`endif

// File: tb/tb_turf_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "turf_defs.svh"

module tb_turf_bridge;

    import turf_pkg::*;

    localparam int RESP_LIMIT = 200;

    logic                                ps_clk;
    logic                                rst_n_i;
    logic                                req_valid_i;
    logic                                req_write_i;
    reg_addr_t                           req_addr_i;
    reg_data_t                           req_wdata_i;
    logic                                resp_valid_o;
    reg_data_t                           resp_rdata_o;
    logic                                resp_err_o;
    lane_flags_t                         aurora_up_i;
    lane_flags_t                         cmd_valid_o;
    lane_flags_t                         cmd_write_o;
    lane_addr_t [`TURF_NUM_LANES-1:0]    cmd_addr_o;
    reg_data_t [`TURF_NUM_LANES-1:0]     cmd_wdata_o;
    lane_flags_t                         resp_valid_i;
    reg_data_t [`TURF_NUM_LANES-1:0]     resp_rdata_i;

    `include "tb_turf_model.svh"

    turf_bridge_top u_turf_bridge_top (.*);

    initial begin
        ps_clk = 1'b0;
        forever #10 ps_clk = ~ps_clk;
    end

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic set_links(input lane_flags_t up, input lane_flags_t mute);
        aurora_up_i = up;
        model_up    = up;
        silent      = mute;
    endtask

    ////////////////////////////////////////////////////////////
    // One access, with the far-end responder of the addressed lane
    ////////////////////////////////////////////////////////////

    task automatic do_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata);
        reg_data_t   exp_rdata;
        reg_data_t   answer;
        logic        exp_err;
        logic        exp_cmd;
        lane_flags_t exp_valid;
        int          lane;
        int          cycles;
        int          delay;
        int          sent;
        predict_access(wr, addr, wdata, exp_rdata, exp_err, exp_cmd);
        lane        = int'(addr[26:25]);
        answer      = '0;
        delay       = 0;
        sent        = 0;
        cycles      = 0;
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        do begin
            @(posedge ps_clk);
            #1;
            cycles++;
            req_valid_i  = 1'b0;
            resp_valid_i = '0;
            exp_valid    = (exp_cmd && cycles == 2) ? lane_flags_t'(1 << lane) : '0;
            check_value("cmd_valid_o", 32'(cmd_valid_o), 32'(exp_valid));
            if (exp_valid != '0) begin
                check_value("cmd_write_o", 32'(cmd_write_o[lane]), 32'(wr));
                check_value("cmd_addr_o", 32'(cmd_addr_o[lane]), 32'(addr[24:0]));
                check_value("cmd_wdata_o", cmd_wdata_o[lane], wdata);
                answer = {7'b0, cmd_addr_o[lane]} ^ 32'h5A5A5A5A;
                if (!silent[lane]) begin
                    delay = 1 + int'(next_random() % 20);
                end
            end else if (!exp_cmd && addr[27] && cycles == 1) begin
                // Stray far-end answer while the lane is idle
                resp_valid_i[lane] = 1'b1;
                resp_rdata_i[lane] = next_random();
            end else if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    resp_valid_i[lane] = 1'b1;
                    resp_rdata_i[lane] = answer;
                    sent               = cycles;
                end
            end
            if (cycles > RESP_LIMIT) begin
                $display("No response from the DUT within %0d cycles", RESP_LIMIT);
                stop_run();
            end
        end while (!resp_valid_o);
        if (!exp_cmd) begin
            check_value("resp_valid_o latency", 32'(cycles), 32'd3);
        end else if (sent != 0) begin
            check_value("resp_valid_o latency", 32'(cycles - sent), 32'd2);
        end else begin
            // Timed out, at least the full wait after the command
            check_value("resp_valid_o timeout", 32'(cycles - 2 >= `TURF_BRIDGE_TIMEOUT), 32'd1);
        end
        check_value("resp_rdata_o", resp_rdata_o, exp_rdata);
        check_value("resp_err_o", 32'(resp_err_o), 32'(exp_err));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        rng_state    = 32'd23599;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        resp_valid_i = '0;
        resp_rdata_i = '0;
        set_links('0, '0);
        repeat (10) @(posedge ps_clk);
        #1;
        rst_n_i = 1'b1;
        check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
        check_value("cmd_valid_o", 32'(cmd_valid_o), 32'd0);

        // Identity, date/version, bridge_type readback
        do_access(1'b0, 28'h0, '0);
        do_access(1'b0, 28'h4, '0);
        do_access(1'b0, 28'h8, '0);
        do_access(1'b1, 28'h8, 32'h0000_00C6);
        do_access(1'b0, 28'h8, '0);
        do_access(1'b1, 28'h8, '0);
        // All lanes in NONE
        for (int i = 0; i < 8; i++)
            do_access(1'b0, crate_addr(i % 4), '0);

        // All lanes AURORA, links up
        set_links('1, '0);
        do_access(1'b1, 28'h8, 32'h55);
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            do_access(r[0], crate_addr(int'(r[2:1])), next_random());
        end

        // Lane 1 link down, lanes 2 and 3 reserved
        set_links(4'b1101, '0);
        do_access(1'b1, 28'h8, 32'hE5);
        for (int i = 1; i < 4; i++)
            do_access(1'b0, crate_addr(i), '0);
        do_access(1'b0, 28'hC, '0);

        // Silent lane 0 times out, then partial status clear
        set_links('1, 4'b0001);
        do_access(1'b1, 28'h8, 32'h55);
        do_access(1'b0, crate_addr(0), '0);
        do_access(1'b0, 28'hC, '0);
        do_access(1'b1, 28'hC, 32'h21);
        do_access(1'b0, 28'hC, '0);

        // Long random mix
        for (int i = 0; i < 400; i++) begin
            r = next_random();
            if (r[7:4] == 4'd0)
                set_links(r[11:8], r[15:12] & r[19:16]);
            if (r[0])
                do_access(r[1], local_addr(), next_random());
            else
                do_access(r[1], crate_addr(int'(r[3:2])), next_random());
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/turf_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "turf_defs.svh"

module turf_bridge_top (
    input  wire                                             ps_clk,
    input  wire                                             rst_n_i,
    // PS register access
    input  wire                                             req_valid_i,
    input  wire                                             req_write_i,
    input  wire turf_pkg::reg_addr_t                        req_addr_i,
    input  wire turf_pkg::reg_data_t                        req_wdata_i,
    output logic                                            resp_valid_o,
    output turf_pkg::reg_data_t                             resp_rdata_o,
    output logic                                            resp_err_o,
    // TURFIO lanes
    input  wire turf_pkg::lane_flags_t                      aurora_up_i,
    output turf_pkg::lane_flags_t                           cmd_valid_o,
    output turf_pkg::lane_flags_t                           cmd_write_o,
    output turf_pkg::lane_addr_t [`TURF_NUM_LANES-1:0]      cmd_addr_o,
    output turf_pkg::reg_data_t [`TURF_NUM_LANES-1:0]       cmd_wdata_o,
    input  wire turf_pkg::lane_flags_t                      resp_valid_i,
    input  wire turf_pkg::reg_data_t [`TURF_NUM_LANES-1:0]  resp_rdata_i
);

    import turf_pkg::*;

    logic                             local_req;
    logic                             local_done;
    logic                             fwd_write;
    logic                             merge_done;
    reg_addr_t                        fwd_addr;
    reg_data_t                        fwd_wdata;
    reg_data_t                        local_rdata;
    lane_flags_t                      lane_req;
    lane_flags_t                      lane_done;
    lane_flags_t                      lane_err;
    lane_flags_t                      lane_timeout;
    lane_flags_t                      lane_invalid;
    reg_data_t [`TURF_NUM_LANES-1:0]  lane_rdata;
    bridge_type_t                     bridge_type;

    turf_req_dispatch u_dispatch (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .local_req_o (local_req),
        .lane_req_o  (lane_req),
        .fwd_write_o (fwd_write),
        .fwd_addr_o  (fwd_addr),
        .fwd_wdata_o (fwd_wdata),
        .done_i      (merge_done)
    );

    ////////////////////////////////////////////////////////////
    // One bridge per TURFIO lane
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `TURF_NUM_LANES; i++) begin : g_lane
        turfio_lane_bridge u_lane (
            .ps_clk            (ps_clk),
            .rst_n_i           (rst_n_i),
            .lane_req_i        (lane_req[i]),
            .fwd_write_i       (fwd_write),
            .fwd_addr_i        (fwd_addr),
            .fwd_wdata_i       (fwd_wdata),
            .kind_i            (bridge_kind_t'(bridge_type[2*i +: 2])),
            .link_up_i         (aurora_up_i[i]),
            .cmd_valid_o       (cmd_valid_o[i]),
            .cmd_write_o       (cmd_write_o[i]),
            .cmd_addr_o        (cmd_addr_o[i]),
            .cmd_wdata_o       (cmd_wdata_o[i]),
            .lane_resp_valid_i (resp_valid_i[i]),
            .lane_resp_rdata_i (resp_rdata_i[i]),
            .done_o            (lane_done[i]),
            .rdata_o           (lane_rdata[i]),
            .err_o             (lane_err[i]),
            .timeout_o         (lane_timeout[i]),
            .invalid_o         (lane_invalid[i])
        );
    end

    turf_id_regs u_id_regs (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .local_req_i   (local_req),
        .fwd_write_i   (fwd_write),
        .fwd_addr_i    (fwd_addr),
        .fwd_wdata_i   (fwd_wdata),
        .timeout_set_i (lane_timeout),
        .invalid_set_i (lane_invalid),
        .bridge_type_o (bridge_type),
        .done_o        (local_done),
        .rdata_o       (local_rdata)
    );

    turf_resp_merge u_merge (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .lane_done_i   (lane_done),
        .lane_rdata_i  (lane_rdata),
        .lane_err_i    (lane_err),
        .local_done_i  (local_done),
        .local_rdata_i (local_rdata),
        .resp_valid_o  (resp_valid_o),
        .resp_rdata_o  (resp_rdata_o),
        .resp_err_o    (resp_err_o),
        .done_o        (merge_done)
    );

endmodule

`default_nettype wire

// File: design/turf_resp_merge.sv
`timescale 1ns/100ps
`default_nettype none

`include "turf_defs.svh"

module turf_resp_merge (
    input  wire                                             ps_clk,
    input  wire                                             rst_n_i,
    input  wire turf_pkg::lane_flags_t                      lane_done_i,
    input  wire turf_pkg::reg_data_t [`TURF_NUM_LANES-1:0]  lane_rdata_i,
    input  wire turf_pkg::lane_flags_t                      lane_err_i,
    input  wire                                             local_done_i,
    input  wire turf_pkg::reg_data_t                        local_rdata_i,
    output logic                                            resp_valid_o,
    output turf_pkg::reg_data_t                             resp_rdata_o,
    output logic                                            resp_err_o,
    output logic                                            done_o
);

    import turf_pkg::*;

    reg_data_t sel_rdata;
    logic      sel_err;
    logic      any_done;

    assign any_done = (|lane_done_i) || local_done_i;
    // Frees the dispatcher as the response is being registered
    assign done_o   = any_done;

    // Sources are one-hot, so an OR of the enabled ones selects
    always_comb begin
        sel_rdata = local_done_i ? local_rdata_i : '0;
        sel_err   = 1'b0;
        for (int i = 0; i < `TURF_NUM_LANES; i++) begin
            if (lane_done_i[i]) begin
                sel_rdata = sel_rdata | lane_rdata_i[i];
                sel_err   = sel_err | lane_err_i[i];
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            resp_valid_o <= 1'b0;
            resp_err_o   <= 1'b0;
        end else begin
            resp_valid_o <= any_done;
            resp_err_o   <= any_done && sel_err;
        end
    end

    always_ff @(posedge ps_clk) begin
        resp_rdata_o <= sel_rdata;
    end

    a_single_source: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $onehot0({lane_done_i, local_done_i}));

endmodule

`default_nettype wire

// File: design/turf_id_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "turf_defs.svh"

module turf_id_regs (
    input  wire                        ps_clk,
    input  wire                        rst_n_i,
    input  wire                        local_req_i,
    input  wire                        fwd_write_i,
    input  wire turf_pkg::reg_addr_t   fwd_addr_i,
    input  wire turf_pkg::reg_data_t   fwd_wdata_i,
    input  wire turf_pkg::lane_flags_t timeout_set_i,
    input  wire turf_pkg::lane_flags_t invalid_set_i,
    output turf_pkg::bridge_type_t     bridge_type_o,
    output logic                       done_o,
    output turf_pkg::reg_data_t        rdata_o
);

    import turf_pkg::*;

    localparam int             NL      = `TURF_NUM_LANES;
    localparam logic [15:0]    FW_DATE = `TURF_FW_DATE;
    localparam reg_data_t      DATEVER = {`TURF_REV_B, FW_DATE[14:0],
                                          `TURF_VER_MAJOR, `TURF_VER_MINOR, `TURF_VER_REV};

    lane_flags_t tmo_flags;
    lane_flags_t inv_flags;
    lane_flags_t tmo_clr;
    lane_flags_t inv_clr;
    logic        in_range;
    logic [1:0]  offset;
    logic        wr_en;
    reg_data_t   read_word;

    // Only the four words at the bottom of local space exist
    assign in_range = (fwd_addr_i[26:4] == '0);
    assign offset   = fwd_addr_i[3:2];
    assign wr_en    = local_req_i && fwd_write_i && in_range;

    // Write-one-to-clear on status
    assign tmo_clr = (wr_en && offset == 2'd3) ? fwd_wdata_i[NL-1:0]    : '0;
    assign inv_clr = (wr_en && offset == 2'd3) ? fwd_wdata_i[2*NL-1:NL] : '0;

    always_comb begin
        case (offset)
            2'd0:    read_word = `TURF_IDENT;
            2'd1:    read_word = DATEVER;
            2'd2:    read_word = reg_data_t'(bridge_type_o);
            default: read_word = reg_data_t'({inv_flags, tmo_flags});
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            done_o        <= 1'b0;
            bridge_type_o <= '0;
            tmo_flags     <= '0;
            inv_flags     <= '0;
        end else begin
            done_o <= local_req_i;
            if (wr_en && offset == 2'd2) begin
                bridge_type_o <= fwd_wdata_i[2*NL-1:0];
            end
            // A set in the same cycle wins over a clear
            tmo_flags <= (tmo_flags & ~tmo_clr) | timeout_set_i;
            inv_flags <= (inv_flags & ~inv_clr) | invalid_set_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (local_req_i) begin
            rdata_o <= (fwd_write_i || !in_range) ? '0 : read_word;
        end
    end

endmodule

`default_nettype wire

// File: design/turfio_lane_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "turf_defs.svh"

module turfio_lane_bridge (
    input  wire                         ps_clk,
    input  wire                         rst_n_i,
    input  wire                         lane_req_i,
    input  wire                         fwd_write_i,
    input  wire turf_pkg::reg_addr_t    fwd_addr_i,
    input  wire turf_pkg::reg_data_t    fwd_wdata_i,
    input  wire turf_pkg::bridge_kind_t kind_i,
    input  wire                         link_up_i,
    output logic                        cmd_valid_o,
    output logic                        cmd_write_o,
    output turf_pkg::lane_addr_t        cmd_addr_o,
    output turf_pkg::reg_data_t         cmd_wdata_o,
    input  wire                         lane_resp_valid_i,
    input  wire turf_pkg::reg_data_t    lane_resp_rdata_i,
    output logic                        done_o,
    output turf_pkg::reg_data_t         rdata_o,
    output logic                        err_o,
    output logic                        timeout_o,
    output logic                        invalid_o
);

    import turf_pkg::*;

    localparam int TMO_W = $clog2(`TURF_BRIDGE_TIMEOUT);

    lane_state_t      state;
    logic [TMO_W-1:0] tmo_cnt;
    logic             issue;
    logic             reject;

    // Link state is sampled with the request
    assign issue  = lane_req_i && (kind_i == BRIDGE_AURORA) && link_up_i;
    assign reject = lane_req_i && ((kind_i == BRIDGE_RSVD2) || (kind_i == BRIDGE_RSVD3) ||
                                   ((kind_i == BRIDGE_AURORA) && !link_up_i));

    ////////////////////////////////////////////////////////////
    // Lane FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state       <= LANE_IDLE;
            tmo_cnt     <= '0;
            cmd_valid_o <= 1'b0;
            done_o      <= 1'b0;
            err_o       <= 1'b0;
            timeout_o   <= 1'b0;
            invalid_o   <= 1'b0;
        end else begin
            cmd_valid_o <= issue;
            done_o      <= 1'b0;
            err_o       <= 1'b0;
            timeout_o   <= 1'b0;
            invalid_o   <= 1'b0;
            case (state)
                LANE_IDLE: begin
                    if (cmd_valid_o) begin
                        // Command is out, start waiting
                        state   <= LANE_WAIT;
                        tmo_cnt <= TMO_W'(`TURF_BRIDGE_TIMEOUT - 1);
                    end else if (lane_req_i && !issue) begin
                        // NONE answers locally, anything else is invalid
                        done_o    <= 1'b1;
                        err_o     <= reject;
                        invalid_o <= reject;
                    end
                end
                LANE_WAIT: begin
                    if (lane_resp_valid_i) begin
                        state  <= LANE_IDLE;
                        done_o <= 1'b1;
                    end else if (tmo_cnt == '0) begin
                        state     <= LANE_IDLE;
                        done_o    <= 1'b1;
                        err_o     <= 1'b1;
                        timeout_o <= 1'b1;
                    end else begin
                        tmo_cnt <= tmo_cnt - 1'b1;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Command and response payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        // Zero unless a real response completes the access
        rdata_o <= (state == LANE_WAIT && lane_resp_valid_i) ? lane_resp_rdata_i : '0;
        if (issue) begin
            cmd_write_o <= fwd_write_i;
            cmd_addr_o  <= lane_addr_t'(fwd_addr_i[24:0]);
            cmd_wdata_o <= fwd_wdata_i;
        end
    end

    a_no_cmd_in_wait: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        state == LANE_WAIT |-> !cmd_valid_o);

endmodule

`default_nettype wire

// File: design/turf_req_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module turf_req_dispatch (
    input  wire                       ps_clk,
    input  wire                       rst_n_i,
    input  wire                       req_valid_i,
    input  wire                       req_write_i,
    input  wire turf_pkg::reg_addr_t  req_addr_i,
    input  wire turf_pkg::reg_data_t  req_wdata_i,
    output logic                      local_req_o,
    output turf_pkg::lane_flags_t     lane_req_o,
    output logic                      fwd_write_o,
    output turf_pkg::reg_addr_t       fwd_addr_o,
    output turf_pkg::reg_data_t       fwd_wdata_o,
    input  wire                       done_i
);

    import turf_pkg::*;

    logic      busy;
    logic      accept;
    lane_sel_t req_lane;

    // Only one access may be in flight
    assign accept   = req_valid_i && !busy;
    assign req_lane = lane_sel_t'(req_addr_i[26:25]);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            busy        <= 1'b0;
            local_req_o <= 1'b0;
            lane_req_o  <= '0;
        end else begin
            local_req_o <= accept && !req_addr_i[27];
            lane_req_o  <= '0;
            if (accept && req_addr_i[27]) begin
                lane_req_o[req_lane] <= 1'b1;
            end
            if (accept) begin
                busy <= 1'b1;
            end else if (done_i) begin
                busy <= 1'b0;
            end
        end
    end

    // Shared request fields, held until the next access
    always_ff @(posedge ps_clk) begin
        if (accept) begin
            fwd_write_o <= req_write_i;
            fwd_addr_o  <= req_addr_i;
            fwd_wdata_o <= req_wdata_i;
        end
    end

    a_no_overlap: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        req_valid_i |-> !busy);

    // The merger only completes an access that was dispatched
    a_done_busy: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        done_i |-> busy);

endmodule

`default_nettype wire

// File: design/turf_pkg.sv
`default_nettype none

`include "turf_defs.svh"

package turf_pkg;

    // Bit 27 picks crate (1) or local (0)
    typedef logic [27:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Crate address bits 26..25
    typedef logic [1:0]  lane_sel_t;
    // Crate address bits 24..0, as seen by the lane
    typedef logic [24:0] lane_addr_t;

    // Two bits per lane, lane 0 lowest
    typedef logic [2*`TURF_NUM_LANES-1:0] bridge_type_t;
    typedef logic [`TURF_NUM_LANES-1:0]   lane_flags_t;

    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_kind_t;

    typedef enum logic {
        LANE_IDLE = 1'b0,
        LANE_WAIT = 1'b1
    } lane_state_t;

endpackage

`default_nettype wire

// File: design/turf_defs.svh
`ifndef TURF_DEFS_SVH
`define TURF_DEFS_SVH

////////////////////////////////////////////////////////////
// Crate bridge sizing
////////////////////////////////////////////////////////////

// TURFIO lanes behind the crate space
`define TURF_NUM_LANES      4

// Cycles a lane waits for its response after the command
`define TURF_BRIDGE_TIMEOUT 64

////////////////////////////////////////////////////////////
// Identity and version fields
////////////////////////////////////////////////////////////

// ASCII "TURF"
`define TURF_IDENT          32'h54555246

`define TURF_VER_MAJOR      4'd0
`define TURF_VER_MINOR      4'd3
`define TURF_VER_REV        8'd4

// Only the low 15 bits reach the date/version word
`define TURF_FW_DATE        16'h5C31
`define TURF_REV_B          1'b0

`endif
